// ==== source/miniAlu_defines.svh ====
`ifndef MINIALU_DEFINES_SVH
`define MINIALU_DEFINES_SVH

// ----------------------------------------
// datapath sizing
// ----------------------------------------
`define DATA_WIDTH 16 // register and operand width
`define REG_COUNT 8 // r0..r7
// instruction words, power of two so the pc wraps on its own
`define PROG_DEPTH 16

// ----------------------------------------
// host bus
// ----------------------------------------
`define APB_ADDR_WIDTH 12 // byte address
`define APB_DATA_WIDTH 32

`endif

// ==== source/isaPkg.sv ====
`default_nettype none
`include "miniAlu_defines.svh"

package isaPkg;

	// ----------------------------------------
	// opcodes, zero is a nop so cleared memory is harmless
	// ----------------------------------------
	typedef enum logic [3:0]
	{
		OP_NOP = 4'h0,
		OP_LDI = 4'h1, // rd = imm
		OP_ADD = 4'h2, // rd = rs1 + rs2
		OP_SUB = 4'h3, // rd = rs1 - rs2
		OP_IMUL = 4'h4, // rd = low nibble product
		OP_IMUL2 = 4'h5, // {rd+1, rd} = rs1 * rs2
		OP_JMP = 4'h6, // pc = imm
		OP_HALT = 4'h7
	} opcodeT;

	typedef logic [$clog2(`REG_COUNT)-1:0] regIndexT;
	typedef logic [`DATA_WIDTH-1:0] immT;

	// instruction word, msb first
	typedef struct packed
	{
		opcodeT opcode;
		regIndexT rd;
		regIndexT rs1;
		regIndexT rs2;
		logic [2:0] pad; // ignored by the decoder
		immT imm;
	} instrT;

endpackage

`default_nettype wire

// ==== source/hostBusPkg.sv ====
`default_nettype none
`include "miniAlu_defines.svh"

package hostBusPkg;

	typedef enum logic [1:0]
	{
		ST_IDLE = 2'd0,
		ST_RUN = 2'd1, // program executing
		ST_DONE = 2'd2 // halt seen, results readable
	} runStateT;

	// ----------------------------------------
	// register map, byte offsets
	// ----------------------------------------
	typedef enum logic [`APB_ADDR_WIDTH-1:0]
	{
		OFS_CTRL = 12'h000,
		OFS_STATUS = 12'h004,
		OFS_PROG = 12'h040, // base of program window
		OFS_REGS = 12'h080 // base of register readback
	} regOffsetT;

	// word index bits inside each window
	localparam logic [`APB_ADDR_WIDTH-1:0] PROG_SPAN_MASK = 12'h03C;
	localparam logic [`APB_ADDR_WIDTH-1:0] REGS_SPAN_MASK = 12'h01C;

	localparam int CTRL_START_BIT = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

endpackage

`default_nettype wire

// ==== source/arrayMultiplier4.sv ====
`timescale 1ns/100ps
`default_nettype none

module arrayMultiplier4
(
	input logic [3:0] a,
	input logic [3:0] b,
	output logic [7:0] product
);
	localparam int N = 4;

	// acc[row] holds the running sum after row, bit N is the row carry out
	wire [N:0] acc [0:N-1];
	wire [N:0] carry [1:N-1]; // ripple chain per adder row

	// row 0 is just the first partial product
	assign acc[0] = {1'b0, a & {N{b[0]}}};

	// ----------------------------------------
	// full-adder rows
	// ----------------------------------------
	for (genvar row = 1; row < N; row++)
	begin : gRow
		assign carry[row][0] = 1'b0; // no carry into the lsb cell

		for (genvar col = 0; col < N; col++)
		begin : gCell
			wire pp;
			wire sumIn;
			assign pp = a[col] & b[row];
			assign sumIn = acc[row-1][col+1]; // previous row shifted down by one
			// full adder cell
			assign acc[row][col] = pp ^ sumIn ^ carry[row][col];
			assign carry[row][col+1] = (pp & sumIn) | (carry[row][col] & (pp ^ sumIn));
		end

		assign acc[row][N] = carry[row][N];
	end

	// one finished bit falls out of every row
	for (genvar row = 0; row < N; row++)
	begin : gLowBits
		assign product[row] = acc[row][0];
	end

	assign product[2*N-1:N] = acc[N-1][N:1]; // upper half from the last row

endmodule

`default_nettype wire

// ==== source/radix4Multiplier.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "miniAlu_defines.svh"

module radix4Multiplier
#(
	parameter int WIDTH = `DATA_WIDTH // must be even
)
(
	input logic [WIDTH-1:0] a,
	input logic [WIDTH-1:0] b,
	output logic [2*WIDTH-1:0] product
);
	localparam int DIGITS = WIDTH / 2; // base-4 digits of b

	// heap-ordered adder tree, leaves at DIGITS-1 and up
	wire [2*WIDTH-1:0] node [0:2*DIGITS-2];

	// ----------------------------------------
	// one partial product per digit
	// ----------------------------------------
	for (genvar d = 0; d < DIGITS; d++)
	begin : gDigit
		logic [WIDTH+1:0] multiple; // up to 3a, two extra bits

		always_comb
		begin
			case (b[2*d +: 2])
				2'd0: multiple = '0;
				2'd1: multiple = {2'b00, a};
				2'd2: multiple = {1'b0, a, 1'b0};
				2'd3: multiple = {2'b00, a} + {1'b0, a, 1'b0}; // a + 2a
				default: multiple = '0;
			endcase
		end

		// weight 4^d
		assign node[DIGITS-1+d] = (2*WIDTH)'(multiple) << (2*d);
	end

	// ----------------------------------------
	// adder tree
	// ----------------------------------------
	for (genvar i = 0; i < DIGITS-1; i++)
	begin : gTree
		assign node[i] = node[2*i+1] + node[2*i+2]; // children sum into parent
	end

	assign product = node[0]; // root

endmodule

`default_nettype wire

// ==== source/miniAluCore.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "miniAlu_defines.svh"

module miniAluCore
(
	input logic Clock,
	input logic rstN,
	input logic start,
	input logic progWrite,
	input logic [$clog2(`PROG_DEPTH)-1:0] progAddr,
	input logic [$bits(isaPkg::instrT)-1:0] progData,
	input isaPkg::regIndexT regReadIdx,
	output logic [`DATA_WIDTH-1:0] regReadData,
	output logic halted
);
	import isaPkg::*;

	localparam int PC_WIDTH = $clog2(`PROG_DEPTH);

	logic [$bits(instrT)-1:0] progMem [`PROG_DEPTH];
	logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
	logic [PC_WIDTH-1:0] pc;
	logic running; // between start and halt
	instrT instr;

	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [7:0] nibbleProd;
	logic [2*`DATA_WIDTH-1:0] wideProd;

	logic wrEn; // rd write
	logic wrHiEn; // rd+1 write, imul2 only
	logic [`DATA_WIDTH-1:0] wrData;
	logic [`DATA_WIDTH-1:0] wrHiData;
	regIndexT rdHi;
	logic jump;

	// ----------------------------------------
	// fetch and operand read
	// ----------------------------------------
	assign instr = instrT'(progMem[pc]);
	assign opA = regFile[instr.rs1];
	assign opB = regFile[instr.rs2];
	assign rdHi = regIndexT'(instr.rd + 1'b1); // wraps r7 -> r0
	assign wrHiData = wideProd[2*`DATA_WIDTH-1:`DATA_WIDTH];

	arrayMultiplier4 arrayMultiplier4_inst
	(
		.a(opA[3:0]),
		.b(opB[3:0]),
		.product(nibbleProd)
	);

	radix4Multiplier #(.WIDTH(`DATA_WIDTH)) radix4Multiplier_inst
	(
		.a(opA),
		.b(opB),
		.product(wideProd)
	);

	// ----------------------------------------
	// decode and alu result select
	// ----------------------------------------
	always_comb
	begin
		wrEn = 1'b0;
		wrHiEn = 1'b0;
		wrData = '0;
		jump = 1'b0;
		halted = 1'b0;
		if (running)
		begin
			case (instr.opcode)
				OP_LDI:
				begin
					wrEn = 1'b1;
					wrData = instr.imm;
				end
				OP_ADD:
				begin
					wrEn = 1'b1;
					wrData = opA + opB; // mod 2^16
				end
				OP_SUB:
				begin
					wrEn = 1'b1;
					wrData = opA - opB;
				end
				OP_IMUL:
				begin
					wrEn = 1'b1;
					wrData = `DATA_WIDTH'(nibbleProd); // zero extended
				end
				OP_IMUL2:
				begin
					wrEn = 1'b1;
					wrHiEn = 1'b1;
					wrData = wideProd[`DATA_WIDTH-1:0];
				end
				OP_JMP: jump = 1'b1;
				OP_HALT: halted = 1'b1; // one cycle, running drops after it
				default: ; // nop and unused codes
			endcase
		end
	end

	// pc counter, start wins over everything
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= '0;
			running <= 1'b0;
		end
		else if (start)
		begin
			pc <= '0;
			running <= 1'b1;
		end
		else if (running)
		begin
			if (halted)
				running <= 1'b0; // pc holds at the halt
			else if (jump)
				pc <= instr.imm[PC_WIDTH-1:0];
			else
				pc <= pc + 1'b1;
		end
	end

	// program memory, host side write port
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `PROG_DEPTH; i++)
				progMem[i] <= '0;
		end
		else if (progWrite)
			progMem[progAddr] <= progData;
	end

	// register file, two write ports for the wide product
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regFile[i] <= '0;
		end
		else
		begin
			if (wrEn)
				regFile[instr.rd] <= wrData;
			if (wrHiEn)
				regFile[rdHi] <= wrHiData; // never the same index as rd
		end
	end

	assign regReadData = regFile[regReadIdx]; // async readback for apb

endmodule

`default_nettype wire

// ==== source/apbHostRegs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "miniAlu_defines.svh"

module apbHostRegs
(
	input logic Clock,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_WIDTH-1:0] paddr,
	input logic [`APB_DATA_WIDTH-1:0] pwdata,
	output logic [`APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic halted,
	input logic [`DATA_WIDTH-1:0] regReadData,
	output logic start,
	output logic progWrite,
	output logic [$clog2(`PROG_DEPTH)-1:0] progAddr,
	output logic [$bits(isaPkg::instrT)-1:0] progData,
	output isaPkg::regIndexT regReadIdx
);
	import hostBusPkg::*;

	runStateT runState;
	logic access; // apb access phase
	logic hitCtrl;
	logic hitStatus;
	logic hitProg;
	logic hitRegs;
	logic unmapped;
	logic busy;
	logic done;

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	assign access = psel & penable;
	assign hitCtrl = (paddr == OFS_CTRL);
	assign hitStatus = (paddr == OFS_STATUS);
	assign hitProg = ((paddr & ~PROG_SPAN_MASK) == OFS_PROG); // also rejects unaligned
	assign hitRegs = ((paddr & ~REGS_SPAN_MASK) == OFS_REGS);
	assign unmapped = !(hitCtrl | hitStatus | hitProg | hitRegs);

	assign busy = (runState == ST_RUN);
	assign done = (runState == ST_DONE);

	// no wait states
	assign pready = 1'b1;
	// unmapped, write to readback, or program write mid run
	assign pslverr = access & (unmapped | (pwrite & hitRegs) | (pwrite & hitProg & busy));

	// start only outside a run, one access cycle wide
	assign start = access & pwrite & hitCtrl & pwdata[CTRL_START_BIT] & !busy;
	assign progWrite = access & pwrite & hitProg & !busy;
	assign progAddr = paddr[2 +: $clog2(`PROG_DEPTH)]; // word index
	assign progData = pwdata;
	assign regReadIdx = paddr[2 +: $bits(regReadIdx)];

	// read mux, ctrl reads back as zero
	always_comb
	begin
		prdata = '0;
		if (hitStatus)
		begin
			prdata[STATUS_BUSY_BIT] = busy;
			prdata[STATUS_DONE_BIT] = done;
		end
		else if (hitRegs)
			prdata = `APB_DATA_WIDTH'(regReadData);
	end

	// ----------------------------------------
	// run state
	// ----------------------------------------
	always_ff @(posedge Clock or negedge rstN)
	begin
		if (!rstN)
			runState <= ST_IDLE;
		else
		begin
			case (runState)
				ST_IDLE, ST_DONE:
					if (start)
						runState <= ST_RUN; // restart clears done
				ST_RUN:
					if (halted)
						runState <= ST_DONE;
				default: runState <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/miniAluTop.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "miniAlu_defines.svh"

module miniAluTop
(
	input logic Clock,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_WIDTH-1:0] paddr,
	input logic [`APB_DATA_WIDTH-1:0] pwdata,
	output logic [`APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	// host to core
	logic start;
	logic progWrite;
	logic [$clog2(`PROG_DEPTH)-1:0] progAddr;
	logic [$bits(isaPkg::instrT)-1:0] progData;
	isaPkg::regIndexT regReadIdx;
	// core to host
	logic [`DATA_WIDTH-1:0] regReadData;
	logic halted;

	apbHostRegs apbHostRegs_inst
	(
		.Clock(Clock),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.halted(halted),
		.regReadData(regReadData),
		.start(start),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.regReadIdx(regReadIdx)
	);

	miniAluCore miniAluCore_inst
	(
		.Clock(Clock),
		.rstN(rstN),
		.start(start),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.regReadIdx(regReadIdx),
		.regReadData(regReadData),
		.halted(halted)
	);

endmodule

`default_nettype wire

// ==== sim/apbHostRegs_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module apbHostRegs_sva
(
	input logic Clock,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic start,
	input hostBusPkg::runStateT runState
);
	import hostBusPkg::*;

	// ----------------------------------------
	// apb response rules
	// ----------------------------------------
	// error response only inside an access phase
	pslverrInAccess: assert property (@(posedge Clock) disable iff (!rstN)
		pslverr |-> (psel && penable))
		else $error("pslverr high outside an APB access phase");

	// ----------------------------------------
	// run control
	// ----------------------------------------
	startOneCycle: assert property (@(posedge Clock) disable iff (!rstN)
		start |=> !start) // single pulse into the core
		else $error("start held longer than one cycle");

	noStartWhileRunning: assert property (@(posedge Clock) disable iff (!rstN)
		start |-> (runState != ST_RUN))
		else $error("start issued while a program is running");

endmodule

// checker rides along with every host register block
bind apbHostRegs apbHostRegs_sva apbHostRegs_sva_inst
(
	.Clock(Clock),
	.rstN(rstN),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.start(start),
	.runState(runState)
);

`default_nettype wire

// ==== sim/miniAluTop_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "miniAlu_defines.svh"

module miniAluTop_tb;
	import isaPkg::*;
	import hostBusPkg::*;

	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 2000;

	logic Clock;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_WIDTH-1:0] paddr;
	logic [`APB_DATA_WIDTH-1:0] pwdata;
	logic [`APB_DATA_WIDTH-1:0] prdata;
	logic pready;
	logic pslverr;

	int passCount;
	int failCount;
	logic [31:0] progQ [$]; // image for the next run

	miniAluTop miniAluTop_inst
	(
		.Clock(Clock),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #10 Clock = ~Clock; // 20 ns period

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t: %s, got %h expected %h", $time, msg, actual, expected);
			failCount++;
		end
		else
			passCount++;
	endtask

	task automatic finishTest(input string name, input int failsAtStart);
		if (failCount == failsAtStart)
			$display("test %s done, no errors", name);
		else
			$display("test %s done, %0d errors", name, failCount - failsAtStart);
	endtask

	// opcode, rd, rs1, rs2, pad, imm from the top
	function automatic logic [31:0] encodeInstr(opcodeT op, regIndexT rd, regIndexT rs1,
		regIndexT rs2, logic [15:0] imm);
		instrT word;
		word.opcode = op;
		word.rd = rd;
		word.rs1 = rs1;
		word.rs2 = rs2;
		word.pad = 3'd0;
		word.imm = imm;
		return word;
	endfunction

	// setup then access, sampled mid access
	task automatic apbTransfer(input logic write, input logic [11:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge Clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge Clock);
		penable <= 1'b1;
		@(negedge Clock);
		rdata = prdata;
		err = pslverr;
		checkEqual({31'd0, pready}, 32'd1, "pready low in access phase"); // no wait states
		@(posedge Clock);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [11:0] addr, output logic [31:0] data, output logic err);
		apbTransfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic writeProgram();
		logic err;
		for (int i = 0; i < progQ.size(); i++)
		begin
			apbWrite(12'(OFS_PROG) + 12'(4 * i), progQ[i], err);
			checkEqual({31'd0, err}, 32'd0, "pslverr on program write");
		end
	endtask

	task automatic startRun();
		logic err;
		apbWrite(12'(OFS_CTRL), 32'h1, err); // bit 0 starts
		checkEqual({31'd0, err}, 32'd0, "pslverr on start");
	endtask

	// poll until done, watchdog catches a stuck core
	task automatic waitDone(output logic [31:0] status);
		logic err;
		status = '0;
		while (!status[STATUS_DONE_BIT])
			apbRead(12'(OFS_STATUS), status, err);
	endtask

	task automatic runProgram();
		logic [31:0] status;
		writeProgram();
		startRun();
		waitDone(status);
		checkEqual(status, 32'h2, "status after halt, done set and busy clear");
	endtask

	task automatic readReg(input int idx, output logic [31:0] data);
		logic err;
		apbRead(12'(OFS_REGS) + 12'(4 * idx), data, err);
		checkEqual({31'd0, err}, 32'd0, "pslverr on register read");
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic resetTest();
		int failsAtStart;
		logic [31:0] data;
		logic err;
		failsAtStart = failCount;
		apbRead(12'(OFS_STATUS), data, err);
		checkEqual(data, 32'd0, "status after reset");
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			readReg(i, data);
			checkEqual(data, 32'd0, $sformatf("r%0d after reset", i));
		end
		apbRead(12'h010, data, err); // gap below the program window
		checkEqual({31'd0, err}, 32'd1, "pslverr on unmapped read 0x010");
		apbRead(12'h0A0, data, err); // just past r7
		checkEqual({31'd0, err}, 32'd1, "pslverr on unmapped read 0x0A0");
		finishTest("reset", failsAtStart);
	endtask

	task automatic addSubTest();
		int failsAtStart;
		logic [15:0] x;
		logic [15:0] y;
		logic [31:0] data;
		failsAtStart = failCount;
		for (int n = 0; n < 4; n++)
		begin
			x = 16'($urandom);
			y = 16'($urandom);
			progQ.delete();
			progQ.push_back(encodeInstr(OP_LDI, 3'd1, 3'd0, 3'd0, x));
			progQ.push_back(encodeInstr(OP_LDI, 3'd2, 3'd0, 3'd0, y));
			progQ.push_back(encodeInstr(OP_ADD, 3'd3, 3'd1, 3'd2, 16'd0));
			progQ.push_back(encodeInstr(OP_SUB, 3'd4, 3'd1, 3'd2, 16'd0));
			progQ.push_back(encodeInstr(OP_SUB, 3'd5, 3'd2, 3'd1, 16'd0)); // other direction
			progQ.push_back(encodeInstr(OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));
			runProgram();
			readReg(3, data);
			checkEqual(data, {16'd0, 16'(x + y)}, "add r1 r2");
			readReg(4, data);
			checkEqual(data, {16'd0, 16'(x - y)}, "sub r1 r2");
			readReg(5, data);
			checkEqual(data, {16'd0, 16'(y - x)}, "sub r2 r1");
		end
		finishTest("add/sub", failsAtStart);
	endtask

	// four nibble pairs per run, 64 runs sweep all 256 pairs
	task automatic imulTest();
		int failsAtStart;
		int k;
		logic [15:0] opA [4];
		logic [15:0] opB [4];
		logic [7:0] expNib;
		logic [31:0] data;
		failsAtStart = failCount;
		for (int run = 0; run < 64; run++)
		begin
			progQ.delete();
			for (int j = 0; j < 4; j++)
			begin
				k = run * 4 + j;
				opA[j] = {12'($urandom), 4'(k >> 4)}; // upper bits must be ignored
				opB[j] = {12'($urandom), 4'(k)};
				progQ.push_back(encodeInstr(OP_LDI, 3'(2 * j), 3'd0, 3'd0, opA[j]));
				progQ.push_back(encodeInstr(OP_LDI, 3'(2 * j + 1), 3'd0, 3'd0, opB[j]));
			end
			for (int j = 0; j < 4; j++)
				progQ.push_back(encodeInstr(OP_IMUL, 3'(2 * j), 3'(2 * j), 3'(2 * j + 1), 16'd0));
			progQ.push_back(encodeInstr(OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));
			runProgram();
			for (int j = 0; j < 4; j++)
			begin
				expNib = {4'd0, opA[j][3:0]} * {4'd0, opB[j][3:0]};
				readReg(2 * j, data);
				checkEqual(data, {24'd0, expNib},
					$sformatf("imul %h x %h", opA[j][3:0], opB[j][3:0]));
			end
		end
		finishTest("imul", failsAtStart);
	endtask

	task automatic imul2Test();
		int failsAtStart;
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] expWide;
		logic [31:0] data;
		failsAtStart = failCount;
		for (int n = 0; n < 4; n++)
		begin
			a = (n == 0) ? 16'hFFFF : 16'($urandom); // largest product first
			b = (n == 0) ? 16'hFFFF : 16'($urandom);
			expWide = {16'd0, a} * {16'd0, b};
			progQ.delete();
			progQ.push_back(encodeInstr(OP_LDI, 3'd1, 3'd0, 3'd0, a));
			progQ.push_back(encodeInstr(OP_LDI, 3'd2, 3'd0, 3'd0, b));
			progQ.push_back(encodeInstr(OP_IMUL2, 3'd3, 3'd1, 3'd2, 16'd0));
			progQ.push_back(encodeInstr(OP_IMUL2, 3'd7, 3'd1, 3'd2, 16'd0)); // high half to r0
			progQ.push_back(encodeInstr(OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));
			runProgram();
			readReg(3, data);
			checkEqual(data, {16'd0, expWide[15:0]}, "imul2 low half in r3");
			readReg(4, data);
			checkEqual(data, {16'd0, expWide[31:16]}, "imul2 high half in r4");
			readReg(7, data);
			checkEqual(data, {16'd0, expWide[15:0]}, "imul2 low half in r7");
			readReg(0, data);
			checkEqual(data, {16'd0, expWide[31:16]}, "imul2 high half wrapped to r0");
		end
		finishTest("imul2", failsAtStart);
	endtask

	task automatic jmpTest();
		int failsAtStart;
		logic [15:0] v1;
		logic [15:0] v3;
		logic [31:0] data;
		failsAtStart = failCount;
		v1 = 16'($urandom);
		v3 = 16'($urandom);
		progQ.delete();
		progQ.push_back(encodeInstr(OP_LDI, 3'd5, 3'd0, 3'd0, v1));
		progQ.push_back(encodeInstr(OP_JMP, 3'd0, 3'd0, 3'd0, 16'hFFF3)); // only low 4 bits count
		progQ.push_back(encodeInstr(OP_LDI, 3'd5, 3'd0, 3'd0, ~v1)); // skipped
		progQ.push_back(encodeInstr(OP_LDI, 3'd6, 3'd0, 3'd0, v3));
		progQ.push_back(encodeInstr(OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));
		runProgram();
		readReg(5, data);
		checkEqual(data, {16'd0, v1}, "r5 untouched by skipped load");
		readReg(6, data);
		checkEqual(data, {16'd0, v3}, "r6 loaded at jump target");
		finishTest("jmp", failsAtStart);
	endtask

	task automatic busyWriteTest();
		int failsAtStart;
		logic [15:0] x;
		logic [31:0] status;
		logic [31:0] data;
		logic err;
		failsAtStart = failCount;
		x = 16'($urandom);
		progQ.delete();
		progQ.push_back(encodeInstr(OP_LDI, 3'd1, 3'd0, 3'd0, x));
		for (int i = 1; i < 14; i++)
			progQ.push_back(32'd0); // nops stretch the run
		progQ.push_back(encodeInstr(OP_HALT, 3'd0, 3'd0, 3'd0, 16'd0));
		progQ.push_back(32'd0);
		writeProgram();
		startRun();
		apbWrite(12'(OFS_PROG), encodeInstr(OP_LDI, 3'd1, 3'd0, 3'd0, ~x), err);
		checkEqual({31'd0, err}, 32'd1, "pslverr on program write during run");
		waitDone(status);
		checkEqual(status, 32'h2, "status after first run");
		// rerun, word 0 should still load x
		startRun();
		apbRead(12'(OFS_STATUS), status, err);
		checkEqual(status, 32'h1, "status after restart, busy and done cleared");
		waitDone(status);
		checkEqual(status, 32'h2, "status after rerun");
		readReg(1, data);
		checkEqual(data, {16'd0, x}, "r1 after rerun, program unchanged");
		finishTest("busy write", failsAtStart);
	endtask

	// ----------------------------------------
	// main sequence and watchdog
	// ----------------------------------------
	initial
	begin
		Clock = 1'b0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		passCount = 0;
		failCount = 0;
		void'($urandom(32'h13fccefd));
		repeat (16) @(posedge Clock);
		rstN <= 1'b1;
		resetTest();
		addSubTest();
		imulTest();
		imul2Test();
		jmpTest();
		busyWriteTest();
		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge Clock);
		$display("timeout: tests did not finish within %0d cycles", NUM_TESTS * CYCLES_PER_TEST);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== miniAluTop.f ====
+incdir+source
source/isaPkg.sv
source/hostBusPkg.sv
source/arrayMultiplier4.sv
source/radix4Multiplier.sv
source/miniAluCore.sv
source/apbHostRegs.sv
source/miniAluTop.sv
sim/apbHostRegs_sva.sv
sim/miniAluTop_tb.sv

// ==== Makefile ====
# Verilator flow for the mini ALU, override any variable on the command line
TOP ?= miniAluTop_tb
RTL_TOP ?= miniAluTop
FILELIST ?= miniAluTop.f
SEED ?= 1
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# verdict comes from the log, not from the simulator exit status
sim: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "no verdict found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
